// ==== gnn_aggr_consts.svh ====
`ifndef GNN_AGGR_CONSTS_SVH
`define GNN_AGGR_CONSTS_SVH

// engine size
`define NUM_EDGE_PE 4
`define PE_IDX_W 2

// graph limits
`define NODE_ID_W 7
`define MAX_DEGREE 8
`define DEGREE_W 4

// feature lanes and sums
`define LANE_W 8
`define AGG_W 11 // MAX_DEGREE * 255 fits

`endif

// ==== gnn_aggr_pkg.sv ====
`include "gnn_aggr_consts.svh"

package gnn_aggr_pkg;

    typedef logic [`NODE_ID_W-1:0] node_id_t;
    typedef logic [`LANE_W-1:0] lane_t;
    typedef logic [`AGG_W-1:0] agg_t;
    typedef logic [`DEGREE_W-1:0] degree_t;

    // what a PE asks the graph memory for
    typedef enum logic {
        kind_neighbors = 1'b0,
        kind_feature   = 1'b1
    } req_kind_t;

    typedef struct packed {
        node_id_t  node;
        req_kind_t kind;
    } mem_req_t;

    typedef struct packed {
        node_id_t node;
        degree_t  degree;
        agg_t     sum0;
        agg_t     sum1;
    } agg_result_t;

    // graph load port target table
    typedef enum logic [1:0] {
        wr_degree   = 2'd0,
        wr_neighbor = 2'd1,
        wr_feature  = 2'd2
    } wr_kind_t;

endpackage

// ==== rr_arbiter.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module rr_arbiter #(
    parameter int n_req = 4,
    parameter type payload_t = logic
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [n_req-1:0]     req,
    input  payload_t             payload [n_req],
    input  logic                 advance,
    output logic [n_req-1:0]     grant,
    output logic                 grant_valid,
    output logic [`PE_IDX_W-1:0] grant_index,
    output payload_t             grant_payload
);

    typedef logic [`PE_IDX_W-1:0] idx_t;

    idx_t last_idx; // previous winner

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant       = '0;
        grant_valid = 1'b0;
        grant_index = '0;
        for (int i = 1; i <= n_req; i++) begin
            idx = (int'(last_idx) + i) % n_req;
            if (!grant_valid && req[idx]) begin
                grant_valid = 1'b1;
                grant_index = idx_t'(idx);
            end
        end
        if (grant_valid) begin
            grant[grant_index] = 1'b1;
        end
    end

    assign grant_payload = payload[grant_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            last_idx <= idx_t'(n_req - 1); // first search begins at 0
        end else if (advance && grant_valid) begin
            last_idx <= grant_index;
        end
    end

endmodule

// ==== task_dispatcher.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module task_dispatcher import gnn_aggr_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    task_valid,
    input  node_id_t                task_node,
    input  logic [`NUM_EDGE_PE-1:0] pe_idle,
    output logic                    task_ready,
    output logic [`NUM_EDGE_PE-1:0] pe_start,
    output node_id_t                start_node
);

    logic                    buf_valid;
    node_id_t                buf_node;
    logic [`NUM_EDGE_PE-1:0] first_idle;
    logic                    issue;

    assign first_idle = pe_idle & (~pe_idle + 1'b1); // lowest set bit
    assign issue      = buf_valid && (|pe_idle);
    assign pe_start   = issue ? first_idle : '0;
    assign start_node = buf_node;

    // buffer frees up in the same cycle it issues
    assign task_ready = !buf_valid || issue;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (task_valid && task_ready) begin
            buf_valid <= 1'b1;
        end else if (issue) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (task_valid && task_ready) begin
            buf_node <= task_node;
        end
    end

endmodule

// ==== edge_pe.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module edge_pe import gnn_aggr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  node_id_t              start_node,
    input  logic                  mem_grant,
    input  logic                  resp_sos,
    input  logic                  resp_eos,
    input  logic [2*`LANE_W-1:0]  resp_data,
    input  degree_t               resp_degree,
    input  logic                  res_take,
    output logic                  idle,
    output logic                  mem_req,
    output req_kind_t             mem_req_kind,
    output node_id_t              mem_req_node,
    output logic                  res_valid,
    output agg_result_t           res_data
);

    localparam int IDX_W = $clog2(`MAX_DEGREE);

    typedef enum logic [2:0] {
        st_idle,
        st_req_neighbors,
        st_stream_neighbors,
        st_req_feature,
        st_wait_feature,
        st_done
    } state_t;

    state_t             state;
    node_id_t           target;
    node_id_t           nbr_ids [`MAX_DEGREE];
    logic [IDX_W-2:0]   fill_cnt;  // beats received, two ids each
    degree_t            degree_q;
    degree_t            fetch_ptr;
    agg_t               sum0;
    agg_t               sum1;
    lane_t              lane0;
    lane_t              lane1;
    node_id_t           id_lo;
    node_id_t           id_hi;

    assign id_lo = resp_data[`NODE_ID_W-1:0];
    assign id_hi = resp_data[2*`NODE_ID_W-1:`NODE_ID_W];
    assign lane0 = resp_data[`LANE_W-1:0];
    assign lane1 = resp_data[2*`LANE_W-1:`LANE_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            fill_cnt  <= '0;
            fetch_ptr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        fill_cnt  <= '0;
                        fetch_ptr <= '0;
                        state     <= st_req_neighbors;
                    end
                end
                st_req_neighbors: begin
                    if (mem_grant) begin
                        state <= st_stream_neighbors;
                    end
                end
                st_stream_neighbors: begin
                    // one beat every cycle until eos
                    fill_cnt <= fill_cnt + 1'b1;
                    if (resp_eos) begin
                        state <= (resp_degree == '0) ? st_done : st_req_feature;
                    end
                end
                st_req_feature: begin
                    if (mem_grant) begin
                        state <= st_wait_feature;
                    end
                end
                st_wait_feature: begin
                    if (resp_eos) begin
                        fetch_ptr <= fetch_ptr + 1'b1;
                        if (fetch_ptr + 1'b1 == degree_q) begin
                            state <= st_done;
                        end else begin
                            state <= st_req_feature;
                        end
                    end
                end
                st_done: begin
                    if (res_take) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            target <= start_node;
            sum0   <= '0;
            sum1   <= '0;
        end
        if (state == st_stream_neighbors) begin
            nbr_ids[{fill_cnt, 1'b0}] <= id_lo;
            nbr_ids[{fill_cnt, 1'b1}] <= id_hi;
            if (resp_sos) begin
                degree_q <= resp_degree;
            end
        end
        if (state == st_wait_feature && resp_eos) begin
            sum0 <= sum0 + agg_t'(lane0);
            sum1 <= sum1 + agg_t'(lane1);
        end
    end

    assign idle         = (state == st_idle);
    assign mem_req      = (state == st_req_neighbors) || (state == st_req_feature);
    assign mem_req_kind = (state == st_req_feature) ? kind_feature : kind_neighbors;
    assign mem_req_node = (state == st_req_feature) ? nbr_ids[fetch_ptr[IDX_W-1:0]] : target;

    assign res_valid       = (state == st_done);
    assign res_data.node   = target;
    assign res_data.degree = degree_q;
    assign res_data.sum0   = sum0;
    assign res_data.sum1   = sum1;

endmodule

// ==== graph_mem.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module graph_mem import gnn_aggr_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          mem_wr_en,
    input  wr_kind_t                      mem_wr_kind,
    input  node_id_t                      mem_wr_node,
    input  logic [$clog2(`MAX_DEGREE)-1:0] mem_wr_index,
    input  logic [2*`LANE_W-1:0]          mem_wr_data,
    input  logic [`NUM_EDGE_PE-1:0]       mem_req,
    input  req_kind_t                     mem_req_kind [`NUM_EDGE_PE],
    input  node_id_t                      mem_req_node [`NUM_EDGE_PE],
    output logic [`NUM_EDGE_PE-1:0]       mem_grant,
    output logic [`NUM_EDGE_PE-1:0]       resp_sos,
    output logic [`NUM_EDGE_PE-1:0]       resp_eos,
    output logic [2*`LANE_W-1:0]          resp_data,
    output degree_t                       resp_degree
);

    localparam int IDX_W = $clog2(`MAX_DEGREE);
    localparam int NUM_NODES = 1 << `NODE_ID_W;

    typedef logic [IDX_W-2:0] beat_t;

    degree_t             degree_tab [NUM_NODES];
    node_id_t            nbr_tab [NUM_NODES*`MAX_DEGREE]; // {node, index}
    logic [2*`LANE_W-1:0] feat_tab [NUM_NODES];

    mem_req_t                req_pl [`NUM_EDGE_PE];
    logic [`NUM_EDGE_PE-1:0] arb_grant;
    logic                    arb_valid;
    logic [`PE_IDX_W-1:0]    arb_index;
    mem_req_t                arb_req;
    logic                    advance;

    logic                 busy;
    logic [`PE_IDX_W-1:0] cur_idx;
    mem_req_t             cur;
    beat_t                beat_cnt;
    beat_t                last_nbr_beat;
    degree_t              cur_deg;
    logic                 last_beat;

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            case (mem_wr_kind)
                wr_degree:   degree_tab[mem_wr_node] <= mem_wr_data[`DEGREE_W-1:0];
                wr_neighbor: nbr_tab[{mem_wr_node, mem_wr_index}] <= mem_wr_data[`NODE_ID_W-1:0];
                wr_feature:  feat_tab[mem_wr_node] <= mem_wr_data;
                default: ;
            endcase
        end
    end

    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : g_req
        assign req_pl[i].node = mem_req_node[i];
        assign req_pl[i].kind = mem_req_kind[i];
    end

    rr_arbiter #(
        .n_req     (`NUM_EDGE_PE),
        .payload_t (mem_req_t)
    ) u_arb (
        .clk           (clk),
        .reset         (reset),
        .req           (mem_req),
        .payload       (req_pl),
        .advance       (advance),
        .grant         (arb_grant),
        .grant_valid   (arb_valid),
        .grant_index   (arb_index),
        .grant_payload (arb_req)
    );

    // no new grant while a stream is running
    assign advance   = arb_valid && !busy;
    assign mem_grant = busy ? '0 : arb_grant;

    assign cur_deg       = degree_tab[cur.node];
    assign last_nbr_beat = (cur_deg == '0) ? '0 : beat_t'((cur_deg - 1'b1) >> 1);
    assign last_beat     = (cur.kind == kind_feature) || (beat_cnt == last_nbr_beat);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
        end else if (advance) begin
            busy     <= 1'b1;
            beat_cnt <= '0;
        end else if (busy) begin
            if (last_beat) begin
                busy <= 1'b0;
            end
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            cur_idx <= arb_index;
            cur     <= arb_req;
        end
    end

    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : g_resp
        assign resp_sos[i] = busy && (cur_idx == i) && (beat_cnt == '0);
        assign resp_eos[i] = busy && (cur_idx == i) && last_beat;
    end

    // two ids per beat, upper bits zero
    assign resp_data = (cur.kind == kind_feature) ? feat_tab[cur.node] :
        {{(2*`LANE_W-2*`NODE_ID_W){1'b0}},
         nbr_tab[{cur.node, beat_cnt, 1'b1}],
         nbr_tab[{cur.node, beat_cnt, 1'b0}]};
    assign resp_degree = cur_deg;

endmodule

// ==== result_collector.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module result_collector import gnn_aggr_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`NUM_EDGE_PE-1:0] res_valid,
    input  agg_result_t             res_data [`NUM_EDGE_PE],
    input  logic                    out_ready,
    output logic [`NUM_EDGE_PE-1:0] res_take,
    output logic                    out_valid,
    output node_id_t                out_node,
    output degree_t                 out_degree,
    output agg_t                    out_sum0,
    output agg_t                    out_sum1
);

    logic [`NUM_EDGE_PE-1:0] arb_grant;
    logic                    arb_valid;
    agg_result_t             arb_result;
    agg_result_t             out_q;
    logic                    take;

    rr_arbiter #(
        .n_req     (`NUM_EDGE_PE),
        .payload_t (agg_result_t)
    ) u_arb (
        .clk           (clk),
        .reset         (reset),
        .req           (res_valid),
        .payload       (res_data),
        .advance       (take),
        .grant         (arb_grant),
        .grant_valid   (arb_valid),
        .grant_index   (),
        .grant_payload (arb_result)
    );

    // register empty or draining this cycle
    assign take     = arb_valid && (!out_valid || out_ready);
    assign res_take = take ? arb_grant : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_q <= arb_result; // held while stalled
        end
    end

    assign out_node   = out_q.node;
    assign out_degree = out_q.degree;
    assign out_sum0   = out_q.sum0;
    assign out_sum1   = out_q.sum1;

endmodule

// ==== gnn_aggr_top.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module gnn_aggr_top import gnn_aggr_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           task_valid,
    input  node_id_t                       task_node,
    output logic                           task_ready,
    output logic                           out_valid,
    output node_id_t                       out_node,
    output degree_t                        out_degree,
    output agg_t                           out_sum0,
    output agg_t                           out_sum1,
    input  logic                           out_ready,
    input  logic                           mem_wr_en,
    input  wr_kind_t                       mem_wr_kind,
    input  node_id_t                       mem_wr_node,
    input  logic [$clog2(`MAX_DEGREE)-1:0] mem_wr_index,
    input  logic [2*`LANE_W-1:0]           mem_wr_data
);

    logic [`NUM_EDGE_PE-1:0] pe_idle;
    logic [`NUM_EDGE_PE-1:0] pe_start;
    node_id_t                start_node;

    logic [`NUM_EDGE_PE-1:0] mem_req;
    req_kind_t               mem_req_kind [`NUM_EDGE_PE];
    node_id_t                mem_req_node [`NUM_EDGE_PE];
    logic [`NUM_EDGE_PE-1:0] mem_grant;
    logic [`NUM_EDGE_PE-1:0] resp_sos;
    logic [`NUM_EDGE_PE-1:0] resp_eos;
    logic [2*`LANE_W-1:0]    resp_data;   // shared by all PEs
    degree_t                 resp_degree;

    logic [`NUM_EDGE_PE-1:0] res_valid;
    agg_result_t             res_data [`NUM_EDGE_PE];
    logic [`NUM_EDGE_PE-1:0] res_take;

    task_dispatcher u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .task_valid (task_valid),
        .task_node  (task_node),
        .pe_idle    (pe_idle),
        .task_ready (task_ready),
        .pe_start   (pe_start),
        .start_node (start_node)
    );

    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : g_pe
        edge_pe u_pe (
            .clk          (clk),
            .reset        (reset),
            .start        (pe_start[i]),
            .start_node   (start_node),
            .mem_grant    (mem_grant[i]),
            .resp_sos     (resp_sos[i]),
            .resp_eos     (resp_eos[i]),
            .resp_data    (resp_data),
            .resp_degree  (resp_degree),
            .res_take     (res_take[i]),
            .idle         (pe_idle[i]),
            .mem_req      (mem_req[i]),
            .mem_req_kind (mem_req_kind[i]),
            .mem_req_node (mem_req_node[i]),
            .res_valid    (res_valid[i]),
            .res_data     (res_data[i])
        );
    end

    graph_mem u_mem (
        .clk          (clk),
        .reset        (reset),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_kind  (mem_wr_kind),
        .mem_wr_node  (mem_wr_node),
        .mem_wr_index (mem_wr_index),
        .mem_wr_data  (mem_wr_data),
        .mem_req      (mem_req),
        .mem_req_kind (mem_req_kind),
        .mem_req_node (mem_req_node),
        .mem_grant    (mem_grant),
        .resp_sos     (resp_sos),
        .resp_eos     (resp_eos),
        .resp_data    (resp_data),
        .resp_degree  (resp_degree)
    );

    result_collector u_collect (
        .clk        (clk),
        .reset      (reset),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .out_ready  (out_ready),
        .res_take   (res_take),
        .out_valid  (out_valid),
        .out_node   (out_node),
        .out_degree (out_degree),
        .out_sum0   (out_sum0),
        .out_sum1   (out_sum1)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== gnn_aggr_checker.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module gnn_aggr_checker import gnn_aggr_pkg::*; (
    input logic                    clk,
    input logic                    reset,
    input logic                    out_valid,
    input logic                    out_ready,
    input node_id_t                out_node,
    input degree_t                 out_degree,
    input agg_t                    out_sum0,
    input agg_t                    out_sum1,
    input logic [`NUM_EDGE_PE-1:0] mem_grant,
    input logic                    task_ready
);

    // stalled result must not move
    property out_hold;
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_node) && $stable(out_degree)
            && $stable(out_sum0) && $stable(out_sum1);
    endproperty

    a_out_hold: assert property (out_hold)
        else $error("result output changed while stalled");

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(mem_grant))
        else $error("more than one memory grant in a cycle");

    a_reset_values: assert property (@(posedge clk) reset |=> !out_valid && task_ready)
        else $error("out_valid or task_ready wrong after reset");

endmodule

// ==== gnn_aggr_tb.sv ====
`timescale 1ns/100ps
`include "gnn_aggr_consts.svh"

module gnn_aggr_tb import gnn_aggr_pkg::*; ();

    localparam int NUM_NODES    = 1 << `NODE_ID_W;
    localparam int IDX_W        = $clog2(`MAX_DEGREE);
    localparam int CLK_PERIOD   = 8;
    localparam int FULL_BASE    = NUM_NODES - `MAX_DEGREE; // nodes with lanes of 255
    localparam int SINGLE_TASKS = 20;
    localparam int BURSTS       = 4;
    localparam int BURST_LEN    = `NUM_EDGE_PE + 2;
    localparam int STALL_TASKS  = 24;
    localparam int FULL_TASKS   = 6;
    localparam int TOTAL_TASKS  = 1 + SINGLE_TASKS + BURSTS * BURST_LEN + STALL_TASKS + FULL_TASKS;
    localparam int MAX_FETCH    = 2 + `MAX_DEGREE / 2 + 3 * `MAX_DEGREE + 4; // cycles per task
    localparam int LOAD_CYCLES  = NUM_NODES * (`MAX_DEGREE + 2) + 20;
    localparam int DRAIN_LIMIT  = 4 * BURST_LEN * MAX_FETCH;
    localparam longint WATCHDOG_NS =
        longint'(LOAD_CYCLES + 4 * TOTAL_TASKS * MAX_FETCH) * CLK_PERIOD;

    typedef logic [2*`LANE_W-1:0] word_t;
    typedef logic [IDX_W-1:0] index_t;

    logic clk;
    logic reset;
    logic task_valid;
    node_id_t task_node;
    logic task_ready;
    logic out_valid;
    node_id_t out_node;
    degree_t out_degree;
    agg_t out_sum0;
    agg_t out_sum1;
    logic out_ready;
    logic mem_wr_en;
    wr_kind_t mem_wr_kind;
    node_id_t mem_wr_node;
    index_t mem_wr_index;
    word_t mem_wr_data;

    // graph model
    int m_degree [NUM_NODES];
    int m_nbr [NUM_NODES][`MAX_DEGREE];
    int m_lane0 [NUM_NODES];
    int m_lane1 [NUM_NODES];

    int issued_cnt [NUM_NODES]; // main process
    int result_cnt [NUM_NODES]; // monitor
    int issued;
    int received;
    int errors;
    int mon_errors;
    logic stall_mode;
    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;

    logic stalled;
    node_id_t held_node;
    degree_t held_degree;
    agg_t held_sum0;
    agg_t held_sum1;

    tb_clock_gen #(.period_ns(CLK_PERIOD), .reset_cycles(4)) u_clk (
        .clk   (clk),
        .reset (reset)
    );

    gnn_aggr_top uut (
        .clk          (clk),
        .reset        (reset),
        .task_valid   (task_valid),
        .task_node    (task_node),
        .task_ready   (task_ready),
        .out_valid    (out_valid),
        .out_node     (out_node),
        .out_degree   (out_degree),
        .out_sum0     (out_sum0),
        .out_sum1     (out_sum1),
        .out_ready    (out_ready),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_kind  (mem_wr_kind),
        .mem_wr_node  (mem_wr_node),
        .mem_wr_index (mem_wr_index),
        .mem_wr_data  (mem_wr_data)
    );

    bind gnn_aggr_top gnn_aggr_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_node   (out_node),
        .out_degree (out_degree),
        .out_sum0   (out_sum0),
        .out_sum1   (out_sum1),
        .mem_grant  (mem_grant),
        .task_ready (task_ready)
    );

    // taps 32,22,2,1
    function automatic logic lfsr_step(inout logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        s = {s[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(inout logic [31:0] s, input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step(s));
        end
        return v;
    endfunction

    function automatic int expected_sum(input int node, input int lane);
        int s;
        s = 0;
        for (int k = 0; k < m_degree[node]; k++) begin
            s += (lane == 0) ? m_lane0[m_nbr[node][k]] : m_lane1[m_nbr[node][k]];
        end
        return s;
    endfunction

    function automatic int error_count();
        return errors + mon_errors;
    endfunction

    task automatic write_mem(input wr_kind_t kind, input int node, input int index, input int data);
        mem_wr_en = 1'b1;
        mem_wr_kind = kind;
        mem_wr_node = node_id_t'(node);
        mem_wr_index = index_t'(index);
        mem_wr_data = word_t'(data);
        @(posedge clk);
        #1;
        mem_wr_en = 1'b0;
    endtask

    // node 0 has no neighbors, nodes 1..3 are full and point at FULL_BASE and up
    task automatic load_graph();
        int deg;
        int nbr;
        for (int n = 0; n < NUM_NODES; n++) begin
            if (n == 0) begin
                deg = 0;
            end else if (n <= 3) begin
                deg = `MAX_DEGREE;
            end else begin
                deg = rand_bits(stim_lfsr, `DEGREE_W) % (`MAX_DEGREE + 1);
            end
            m_degree[n] = deg;
            write_mem(wr_degree, n, 0, deg);
            for (int k = 0; k < `MAX_DEGREE; k++) begin
                if (n >= 1 && n <= 3) begin
                    nbr = FULL_BASE + rand_bits(stim_lfsr, IDX_W);
                end else begin
                    nbr = rand_bits(stim_lfsr, `NODE_ID_W);
                end
                m_nbr[n][k] = nbr;
                write_mem(wr_neighbor, n, k, nbr);
            end
            if (n >= FULL_BASE) begin
                m_lane0[n] = 255;
                m_lane1[n] = 255;
            end else begin
                m_lane0[n] = rand_bits(stim_lfsr, `LANE_W);
                m_lane1[n] = rand_bits(stim_lfsr, `LANE_W);
            end
            write_mem(wr_feature, n, 0, (m_lane1[n] << `LANE_W) | m_lane0[n]);
        end
    endtask

    task automatic send_task(input int node);
        task_valid = 1'b1;
        task_node = node_id_t'(node);
        @(negedge clk);
        while (!task_ready) begin
            @(negedge clk);
        end
        @(posedge clk); // accepted here
        #1;
        task_valid = 1'b0;
        issued_cnt[node]++;
        issued++;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (received < issued && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (received < issued) begin
            $display("results stopped arriving: %0d of %0d after %0d cycles",
                     received, issued, cycles);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("[%0t] %s: %0d errors", $time, name, error_count() - err_mark);
    endtask

    task automatic check_result(input int node, input int degree, input int s0, input int s1);
        assert (result_cnt[node] < issued_cnt[node]) else begin
            $display("ERROR %0t: node %0d gave a result without an open task", $time, node);
            mon_errors++;
        end
        assert (degree == m_degree[node]) else begin
            $display("ERROR %0t: node %0d degree %0d, expected %0d",
                     $time, node, degree, m_degree[node]);
            mon_errors++;
        end
        assert (s0 == expected_sum(node, 0)) else begin
            $display("ERROR %0t: node %0d sum0 %0d, expected %0d",
                     $time, node, s0, expected_sum(node, 0));
            mon_errors++;
        end
        assert (s1 == expected_sum(node, 1)) else begin
            $display("ERROR %0t: node %0d sum1 %0d, expected %0d",
                     $time, node, s1, expected_sum(node, 1));
            mon_errors++;
        end
        result_cnt[node]++;
        received++;
    endtask

    // sampled mid-cycle, a transfer happens at the next rising edge
    always @(negedge clk) begin
        if (reset) begin
            received = 0;
            mon_errors = 0;
            stalled = 1'b0;
            for (int n = 0; n < NUM_NODES; n++) begin
                result_cnt[n] = 0;
            end
        end else begin
            if (stalled) begin
                assert (out_valid && out_node == held_node && out_degree == held_degree
                        && out_sum0 == held_sum0 && out_sum1 == held_sum1)
                else begin
                    $display("ERROR %0t: output changed while out_ready was low", $time);
                    mon_errors++;
                end
            end
            if (out_valid && out_ready) begin
                check_result(int'(out_node), int'(out_degree), int'(out_sum0), int'(out_sum1));
            end
            stalled = out_valid && !out_ready;
            held_node = out_node;
            held_degree = out_degree;
            held_sum0 = out_sum0;
            held_sum1 = out_sum1;
        end
    end

    initial begin
        ready_lfsr = 32'h6a0b;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = stall_mode ? lfsr_step(ready_lfsr) : 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns, %0d of %0d results seen",
                 WATCHDOG_NS, received, issued);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int err_mark;
        task_valid = 1'b0;
        task_node = '0;
        mem_wr_en = 1'b0;
        mem_wr_kind = wr_degree;
        mem_wr_node = '0;
        mem_wr_index = '0;
        mem_wr_data = '0;
        stall_mode = 1'b0;
        stim_lfsr = 32'h6a0b;
        issued = 0;
        errors = 0;
        for (int n = 0; n < NUM_NODES; n++) begin
            issued_cnt[n] = 0;
        end
        @(negedge reset);
        @(posedge clk);
        #1;
        load_graph();

        err_mark = error_count();
        send_task(0);
        wait_drain();
        report_test("zero degree", err_mark);

        err_mark = error_count();
        repeat (SINGLE_TASKS) begin
            send_task(rand_bits(stim_lfsr, `NODE_ID_W));
            wait_drain();
        end
        report_test("single tasks", err_mark);

        err_mark = error_count();
        repeat (BURSTS) begin
            repeat (BURST_LEN) send_task(rand_bits(stim_lfsr, `NODE_ID_W));
            wait_drain();
        end
        report_test("bursts", err_mark);

        err_mark = error_count();
        @(negedge clk);
        stall_mode = 1'b1;
        @(posedge clk);
        #1;
        repeat (STALL_TASKS) send_task(rand_bits(stim_lfsr, `NODE_ID_W));
        wait_drain();
        @(negedge clk);
        stall_mode = 1'b0;
        @(posedge clk);
        #1;
        report_test("back-pressure", err_mark);

        err_mark = error_count();
        for (int i = 0; i < FULL_TASKS; i++) begin
            send_task(1 + i % 3);
        end
        wait_drain();
        report_test("full degree", err_mark);

        // every issued task needs exactly one result
        assert (received == issued) else begin
            $display("ERROR %0t: %0d tasks issued but %0d results", $time, issued, received);
            errors++;
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            assert (result_cnt[n] == issued_cnt[n]) else begin
                $display("ERROR %0t: node %0d issued %0d times, %0d results",
                         $time, n, issued_cnt[n], result_cnt[n]);
                errors++;
            end
        end
        $display("tasks %0d, results %0d, errors %0d", issued, received, error_count());
        if (error_count() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== gnn_aggr_top.f ====
+incdir+.
gnn_aggr_pkg.sv
rr_arbiter.sv
task_dispatcher.sv
edge_pe.sv
graph_mem.sv
result_collector.sv
gnn_aggr_top.sv
tb_clock_gen.sv
gnn_aggr_checker.sv
gnn_aggr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gnn_aggr_tb
FILELIST  ?= gnn_aggr_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a pass"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
